//--- rtl/decode_pkg.sv
//--------------------------------------
// decode stage shared definitions
// sizes, opcode and prefix bytes, enums
//--------------------------------------
`default_nettype none

package decode_pkg;

    // sizes
    localparam int unsigned dec_buf_bytes = 12;           // window depth
    localparam int unsigned fetch_bytes   = 8;            // fetch port width
    localparam logic [31:0] startup_eip   = 32'h0000_fff0; // eip out of reset

    //--------------------------------------
    // opcodes, group bases have low 3 bits zero
    localparam logic [7:0] op_nop     = 8'h90;
    localparam logic [7:0] op_hlt     = 8'hf4;
    localparam logic [7:0] op_inc     = 8'h40; // 40..47
    localparam logic [7:0] op_dec     = 8'h48; // 48..4f
    localparam logic [7:0] op_mov_r8  = 8'hb0; // b0..b7
    localparam logic [7:0] op_mov_r   = 8'hb8; // b8..bf
    localparam logic [7:0] op_jmp8    = 8'heb;
    localparam logic [7:0] op_jmp     = 8'he9;
    localparam logic [7:0] op_call    = 8'he8;
    localparam logic [7:0] op_twobyte = 8'h0f; // escape
    localparam logic [7:0] op_cpuid   = 8'ha2; // second byte after 0f

    //--------------------------------------
    // prefixes
    localparam logic [7:0] pfx_opsize = 8'h66;
    localparam logic [7:0] pfx_lock   = 8'hf0;
    localparam logic [7:0] pfx_repnz  = 8'hf2;
    localparam logic [7:0] pfx_repz   = 8'hf3;
    localparam logic [7:0] pfx_es     = 8'h26;
    localparam logic [7:0] pfx_cs     = 8'h2e;
    localparam logic [7:0] pfx_ss     = 8'h36;
    localparam logic [7:0] pfx_ds     = 8'h3e;
    localparam logic [7:0] pfx_fs     = 8'h64;
    localparam logic [7:0] pfx_gs     = 8'h65;

    typedef enum logic [2:0] {
        cmd_nop, cmd_inc, cmd_dec, cmd_mov_imm,
        cmd_jmp, cmd_call, cmd_hlt, cmd_cpuid
    } dec_cmd_t;

    typedef enum logic [1:0] {rep_none, rep_nz, rep_z} rep_t;

    typedef enum logic [2:0] {
        seg_none, seg_es, seg_cs, seg_ss, seg_ds, seg_fs, seg_gs
    } seg_t;

endpackage

`default_nettype wire

//--- rtl/decode_regs.sv
//--------------------------------------
// decode byte window
// drops consumed head bytes, appends fetch bytes
//--------------------------------------
`timescale 1ns/1ns
`default_nettype none

module decode_regs (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        dec_reset,
    input  logic [3:0]  fetch_valid,
    input  logic [63:0] fetch,
    input  logic [3:0]  consume_count,
    output logic [3:0]  dec_acceptable,
    output logic [95:0] window,
    output logic [3:0]  window_count
);
    import decode_pkg::*;

    logic [3:0]  free_bytes;   // space at start of cycle
    logic [3:0]  take;         // fetch bytes accepted this cycle
    logic [3:0]  keep_count;   // bytes left after consume
    logic [95:0] shifted;
    logic [95:0] kept;
    logic [63:0] fetch_taken;
    logic [95:0] appended;

    assign free_bytes     = 4'(dec_buf_bytes) - window_count;
    assign dec_acceptable = (free_bytes > 4'(fetch_bytes)) ? 4'(fetch_bytes) : free_bytes;
    assign take           = (fetch_valid < dec_acceptable) ? fetch_valid : dec_acceptable;

    // dec_reset throws away old bytes, new fetch still lands
    assign keep_count = dec_reset ? 4'd0 : window_count - consume_count;
    assign shifted    = window >> {consume_count, 3'b000};

    always_comb begin
        for (int i = 0; i < dec_buf_bytes; i++) begin
            kept[i*8 +: 8] = (4'(i) < keep_count) ? shifted[i*8 +: 8] : 8'h00; // clear stale
        end
        for (int i = 0; i < fetch_bytes; i++) begin
            fetch_taken[i*8 +: 8] = (4'(i) < take) ? fetch[i*8 +: 8] : 8'h00;
        end
    end

    assign appended = {32'd0, fetch_taken} << {keep_count, 3'b000}; // behind kept bytes

    //--------------------------------------
    always_ff @(posedge clk) begin
        window <= kept | appended;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            window_count <= 4'd0;
        end else begin
            window_count <= keep_count + take;
        end
    end

    // ctrl must never consume bytes that are not there
    a_consume_in_window: assert property (@(posedge clk) disable iff (!rst_n)
        consume_count <= window_count);

    a_count_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        window_count <= 4'(dec_buf_bytes));

endmodule

`default_nettype wire

//--- rtl/decode_prefix.sv
//--------------------------------------
// prefix tracker
// takes one prefix byte per cycle from the head
// and holds prefix state until the instr ends
//--------------------------------------
`timescale 1ns/1ns
`default_nettype none

module decode_prefix (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [95:0]       window,
    input  logic [3:0]        window_count,
    input  logic              default_32bit,
    input  logic              instr_prefix,
    input  logic              instr_finished,
    output logic              is_prefix,
    output logic [3:0]        prefix_count,
    output logic              dec_operand_32bit,
    output decode_pkg::rep_t  dec_rep,
    output logic              dec_lock,
    output decode_pkg::seg_t  dec_seg
);
    import decode_pkg::*;

    logic [7:0] head;
    logic       head_is_pfx;
    logic       opsize_q;    // 66 seen

    assign head = window[7:0];

    // 0f is an opcode escape here, length decode handles it
    always_comb begin
        case (head)
            pfx_opsize, pfx_lock, pfx_repnz, pfx_repz,
            pfx_es, pfx_cs, pfx_ss, pfx_ds, pfx_fs, pfx_gs: head_is_pfx = 1'b1;
            default:                                        head_is_pfx = 1'b0;
        endcase
    end

    assign is_prefix         = (window_count != 4'd0) && head_is_pfx;
    assign dec_operand_32bit = default_32bit ^ opsize_q; // 66 flips default

    //--------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            opsize_q     <= 1'b0;
            dec_lock     <= 1'b0;
            dec_rep      <= rep_none;
            dec_seg      <= seg_none;
            prefix_count <= 4'd0;
        end else if (instr_finished) begin
            opsize_q     <= 1'b0;
            dec_lock     <= 1'b0;
            dec_rep      <= rep_none;
            dec_seg      <= seg_none;
            prefix_count <= 4'd0;
        end else if (instr_prefix) begin
            if (prefix_count != 4'hf) prefix_count <= prefix_count + 4'd1; // saturate
            case (head)
                pfx_opsize: opsize_q <= 1'b1;
                pfx_lock:   dec_lock <= 1'b1;
                pfx_repnz:  dec_rep  <= rep_nz;  // last rep wins
                pfx_repz:   dec_rep  <= rep_z;
                pfx_es:     dec_seg  <= seg_es;  // last seg wins
                pfx_cs:     dec_seg  <= seg_cs;
                pfx_ss:     dec_seg  <= seg_ss;
                pfx_ds:     dec_seg  <= seg_ds;
                pfx_fs:     dec_seg  <= seg_fs;
                pfx_gs:     dec_seg  <= seg_gs;
                default:    ;
            endcase
        end
    end

    a_prefix_only_on_pfx: assert property (@(posedge clk) disable iff (!rst_n)
        instr_prefix |-> is_prefix);

endmodule

`default_nettype wire

//--- rtl/decode_length.sv
//--------------------------------------
// opcode and length decode
// classifies the head opcode, checks that
// all bytes are in, extracts cmd, reg, imm
//--------------------------------------
`timescale 1ns/1ns
`default_nettype none

module decode_length (
    input  logic                  [95:0] window,
    input  logic                  [3:0]  window_count,
    input  logic                         dec_operand_32bit,
    output logic                  [3:0]  instr_len,
    output logic                         invalid_op,
    output decode_pkg::dec_cmd_t         dec_cmd,
    output logic                  [2:0]  dec_reg,
    output logic                         dec_is_8bit,
    output logic                  [31:0] dec_imm
);
    import decode_pkg::*;

    logic [7:0]  b0;        // opcode
    logic [7:0]  b1;        // imm8 / rel8 / 0f second byte
    logic [3:0]  imm_len;   // 2 or 4 by operand size
    logic [31:0] imm_wide;
    logic [3:0]  full_len;
    logic [3:0]  need_len;  // bytes before the opcode can be judged
    logic        op_ok;

    assign b0       = window[7:0];
    assign b1       = window[15:8];
    assign imm_len  = dec_operand_32bit ? 4'd4 : 4'd2;
    assign imm_wide = dec_operand_32bit ? window[39:8] : {16'd0, window[23:8]};

    //--------------------------------------
    always_comb begin
        full_len    = 4'd1;
        need_len    = 4'd1;
        op_ok       = 1'b1;
        dec_cmd     = cmd_nop;
        dec_reg     = 3'd0;
        dec_is_8bit = 1'b0;
        dec_imm     = 32'd0;
        if (b0 == op_nop) begin
            dec_cmd = cmd_nop;
        end else if (b0 == op_hlt) begin
            dec_cmd = cmd_hlt;
        end else if (b0[7:3] == op_inc[7:3]) begin
            dec_cmd = cmd_inc;
            dec_reg = b0[2:0];
        end else if (b0[7:3] == op_dec[7:3]) begin
            dec_cmd = cmd_dec;
            dec_reg = b0[2:0];
        end else if (b0[7:3] == op_mov_r8[7:3]) begin
            dec_cmd     = cmd_mov_imm;
            dec_reg     = b0[2:0];
            dec_is_8bit = 1'b1;
            full_len    = 4'd2;
            dec_imm     = {24'd0, b1};         // imm8 zero ext
        end else if (b0[7:3] == op_mov_r[7:3]) begin
            dec_cmd  = cmd_mov_imm;
            dec_reg  = b0[2:0];
            full_len = 4'd1 + imm_len;
            dec_imm  = imm_wide;
        end else if (b0 == op_jmp8) begin
            dec_cmd  = cmd_jmp;
            full_len = 4'd2;
            dec_imm  = {{24{b1[7]}}, b1};      // rel8 sign ext
        end else if (b0 == op_jmp) begin
            dec_cmd  = cmd_jmp;
            full_len = 4'd1 + imm_len;
            dec_imm  = imm_wide;
        end else if (b0 == op_call) begin
            dec_cmd  = cmd_call;
            full_len = 4'd1 + imm_len;
            dec_imm  = imm_wide;
        end else if (b0 == op_twobyte) begin
            need_len = 4'd2;                   // judged once second byte is in
            full_len = 4'd2;
            if (b1 == op_cpuid) begin
                dec_cmd = cmd_cpuid;
            end else begin
                op_ok = 1'b0;
            end
        end else begin
            op_ok = 1'b0;
        end
    end

    // length only once every byte is in the window
    assign instr_len  = (op_ok && window_count >= full_len) ? full_len : 4'd0;
    assign invalid_op = !op_ok && (window_count >= need_len);

endmodule

`default_nettype wire

//--- rtl/decode_ctrl.sv
//--------------------------------------
// decode control
// prefix vs instr arbitration, consume count,
// sticky faults and the instruction pointer
//--------------------------------------
`timescale 1ns/1ns
`default_nettype none

module decode_ctrl (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        dec_reset,
    input  logic        micro_busy,
    input  logic        pr_reset,
    input  logic [31:0] prefetch_eip,
    input  logic [3:0]  fetch_valid,
    input  logic        fetch_limit,
    input  logic        fetch_page_fault,
    input  logic        is_prefix,
    input  logic [3:0]  window_count,
    input  logic [3:0]  prefix_count,
    input  logic [3:0]  instr_len,
    input  logic        invalid_op,
    input  logic        dec_lock,
    output logic        instr_prefix,
    output logic        instr_finished,
    output logic [3:0]  consume_count,
    output logic        dec_ready,
    output logic [3:0]  dec_consumed,
    output logic        dec_gp_fault,
    output logic        dec_ud_fault,
    output logic        dec_pf_fault,
    output logic [31:0] eip,
    output logic [31:0] dec_eip
);
    import decode_pkg::*;

    logic stop;          // any fault set
    logic head_stalled;  // incomplete, non-prefix head
    logic ud_event;
    logic gp_cond, gp_last;
    logic pf_cond, pf_last;

    assign stop = dec_gp_fault | dec_ud_fault | dec_pf_fault;

    assign instr_prefix = !stop && !dec_reset && !micro_busy && is_prefix
                          && (window_count != 4'd0);
    // locked instr never issues, it faults instead
    assign dec_ready = !stop && !dec_reset && !is_prefix && (instr_len != 4'd0)
                       && !micro_busy && !dec_lock;
    assign instr_finished = dec_ready || dec_reset;

    assign consume_count = instr_prefix ? 4'd1 : (dec_ready ? instr_len : 4'd0);
    assign dec_consumed  = dec_ready ? prefix_count + instr_len : 4'd0;
    assign dec_eip       = eip + {28'd0, dec_consumed};

    //--------------------------------------
    // faults
    assign ud_event = !stop && !dec_reset && !is_prefix
                      && (invalid_op || (dec_lock && instr_len != 4'd0));
    assign head_stalled = !stop && !dec_reset && !is_prefix && (instr_len == 4'd0)
                          && !invalid_op && (fetch_valid == 4'd0);
    assign gp_cond = head_stalled && fetch_limit;
    assign pf_cond = head_stalled && fetch_page_fault;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gp_last      <= 1'b0;
            pf_last      <= 1'b0;
            dec_gp_fault <= 1'b0;
            dec_ud_fault <= 1'b0;
            dec_pf_fault <= 1'b0;
        end else begin
            gp_last <= gp_cond;  // two cycle qualifier
            pf_last <= pf_cond;
            if (dec_reset) begin
                dec_gp_fault <= 1'b0;
                dec_ud_fault <= 1'b0;
                dec_pf_fault <= 1'b0;
            end else begin
                if (ud_event)           dec_ud_fault <= 1'b1;
                if (gp_cond && gp_last) dec_gp_fault <= 1'b1;
                if (pf_cond && pf_last) dec_pf_fault <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)         eip <= startup_eip;
        else if (pr_reset)  eip <= prefetch_eip;  // redirect wins
        else if (dec_ready) eip <= dec_eip;
    end

    // a set fault holds and keeps issue off until dec_reset
    a_no_ready_on_fault: assert property (@(posedge clk) disable iff (!rst_n)
        stop && !dec_reset |=> stop && !dec_ready);
    // a prefix byte never decodes as an opcode
    a_prefix_not_opcode: assert property (@(posedge clk) disable iff (!rst_n)
        is_prefix |-> instr_len == 4'd0);

endmodule

`default_nettype wire

//--- rtl/decode.sv
//--------------------------------------
// instruction decode stage top
// window, prefix tracker, length decode, ctrl
//--------------------------------------
`timescale 1ns/1ns
`default_nettype none

module decode (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         dec_reset,
    input  logic                         default_32bit,
    input  logic                         pr_reset,
    input  logic                  [31:0] prefetch_eip,
    input  logic                  [3:0]  fetch_valid,
    input  logic                  [63:0] fetch,
    input  logic                         fetch_limit,
    input  logic                         fetch_page_fault,
    input  logic                         micro_busy,
    output logic                  [3:0]  dec_acceptable,
    output logic                         dec_ready,
    output logic                  [3:0]  dec_consumed,
    output logic                  [31:0] eip,
    output logic                  [31:0] dec_eip,
    output logic                         dec_gp_fault,
    output logic                         dec_ud_fault,
    output logic                         dec_pf_fault,
    output logic                         dec_operand_32bit,
    output decode_pkg::rep_t             dec_rep,
    output logic                         dec_lock,
    output decode_pkg::seg_t             dec_seg,
    output decode_pkg::dec_cmd_t         dec_cmd,
    output logic                  [2:0]  dec_reg,
    output logic                         dec_is_8bit,
    output logic                  [31:0] dec_imm
);
    logic [95:0] window;          // head byte lowest
    logic [3:0]  window_count;
    logic [3:0]  consume_count;
    logic        is_prefix, instr_prefix, instr_finished;
    logic [3:0]  prefix_count;
    logic [3:0]  instr_len;
    logic        invalid_op;

    decode_regs u_regs (.clk, .rst_n, .dec_reset, .fetch_valid, .fetch, .consume_count,
        .dec_acceptable, .window, .window_count);

    decode_prefix u_prefix (.clk, .rst_n, .window, .window_count, .default_32bit,
        .instr_prefix, .instr_finished, .is_prefix, .prefix_count, .dec_operand_32bit,
        .dec_rep, .dec_lock, .dec_seg);

    decode_length u_length (.window, .window_count, .dec_operand_32bit, .instr_len,
        .invalid_op, .dec_cmd, .dec_reg, .dec_is_8bit, .dec_imm);

    decode_ctrl u_ctrl (.clk, .rst_n, .dec_reset, .micro_busy, .pr_reset, .prefetch_eip,
        .fetch_valid, .fetch_limit, .fetch_page_fault, .is_prefix, .window_count,
        .prefix_count, .instr_len, .invalid_op, .dec_lock, .instr_prefix, .instr_finished,
        .consume_count, .dec_ready, .dec_consumed, .dec_gp_fault, .dec_ud_fault,
        .dec_pf_fault, .eip, .dec_eip);

endmodule

`default_nettype wire

//--- test/decode_tb_cases.svh
//--------------------------------------
// decode testbench case table
// one row per instruction, in stream order
//--------------------------------------
`ifndef DECODE_TB_CASES_SVH
`define DECODE_TB_CASES_SVH

// per row the byte count, the bytes with the first one leftmost and default_32bit
// then expected cmd, reg, is_8bit, imm, rep, seg, operand_32bit and consumed
task automatic load_cases();
    add_case(1, 64'h90,             1, cmd_nop,     0, 0, 32'h0,        rep_none, seg_none, 1, 1);
    add_case(1, 64'hf4,             1, cmd_hlt,     0, 0, 32'h0,        rep_none, seg_none, 1, 1);
    add_case(1, 64'h43,             1, cmd_inc,     3, 0, 32'h0,        rep_none, seg_none, 1, 1);
    add_case(1, 64'h4e,             1, cmd_dec,     6, 0, 32'h0,        rep_none, seg_none, 1, 1);
    add_case(2, 64'hb27f,           1, cmd_mov_imm, 2, 1, 32'h7f,       rep_none, seg_none, 1, 2);
    add_case(5, 64'hb978563412,     1, cmd_mov_imm, 1, 0, 32'h12345678, rep_none, seg_none, 1, 5);
    add_case(4, 64'h66bb3412,       1, cmd_mov_imm, 3, 0, 32'h1234,     rep_none, seg_none, 0, 4);
    add_case(3, 64'hbdcdab,         0, cmd_mov_imm, 5, 0, 32'habcd,     rep_none, seg_none, 0, 3);
    add_case(6, 64'h66be44332211,   0, cmd_mov_imm, 6, 0, 32'h11223344, rep_none, seg_none, 1, 6);
    add_case(2, 64'hebf0,           1, cmd_jmp,     0, 0, 32'hfffffff0, rep_none, seg_none, 1, 2);
    add_case(2, 64'heb10,           0, cmd_jmp,     0, 0, 32'h10,       rep_none, seg_none, 0, 2);
    add_case(5, 64'he900010000,     1, cmd_jmp,     0, 0, 32'h100,      rep_none, seg_none, 1, 5);
    add_case(3, 64'he9ff80,         0, cmd_jmp,     0, 0, 32'h80ff,     rep_none, seg_none, 0, 3);
    add_case(3, 64'he8feff,         0, cmd_call,    0, 0, 32'hfffe,     rep_none, seg_none, 0, 3);
    add_case(4, 64'h66e81020,       1, cmd_call,    0, 0, 32'h2010,     rep_none, seg_none, 0, 4);
    add_case(6, 64'h66e8efbeadde,   0, cmd_call,    0, 0, 32'hdeadbeef, rep_none, seg_none, 1, 6);
    add_case(2, 64'h0fa2,           1, cmd_cpuid,   0, 0, 32'h0,        rep_none, seg_none, 1, 2);
    add_case(4, 64'hf3f22e90,       1, cmd_nop,     0, 0, 32'h0,        rep_nz,   seg_cs,   1, 4);
    add_case(5, 64'h263ef36445,     1, cmd_inc,     5, 0, 32'h0,        rep_z,    seg_fs,   1, 5);
    add_case(3, 64'h666640,         1, cmd_inc,     0, 0, 32'h0,        rep_none, seg_none, 0, 3);
    add_case(3, 64'h366548,         1, cmd_dec,     0, 0, 32'h0,        rep_none, seg_gs,   1, 3);
    add_case(3, 64'hf2b080,         1, cmd_mov_imm, 0, 1, 32'h80,       rep_nz,   seg_none, 1, 3);
    add_case(1, 64'hf4,             0, cmd_hlt,     0, 0, 32'h0,        rep_none, seg_none, 0, 1);
    add_case(3, 64'h3eb7ff,         1, cmd_mov_imm, 7, 1, 32'hff,       rep_none, seg_ds,   1, 3);
    add_case(1, 64'h4f,             1, cmd_dec,     7, 0, 32'h0,        rep_none, seg_none, 1, 1);
    add_case(4, 64'hf3266690,       1, cmd_nop,     0, 0, 32'h0,        rep_z,    seg_es,   0, 4);
endtask

`endif

//--- test/decode_tb.sv
//--------------------------------------
// decode stage testbench
// random feeder and busy, table checker,
// eip tracking, UD/GP/PF fault phases
//--------------------------------------
`timescale 1ns/1ns
`default_nettype none

module decode_tb;
    import decode_pkg::*;

    logic        clk, rst_n, dec_reset, default_32bit, pr_reset, micro_busy;
    logic        fetch_limit, fetch_page_fault;
    logic [31:0] prefetch_eip;
    logic [3:0]  fetch_valid;
    logic [63:0] fetch;
    logic [3:0]  dec_acceptable, dec_consumed;
    logic        dec_ready, dec_gp_fault, dec_ud_fault, dec_pf_fault;
    logic        dec_operand_32bit, dec_lock, dec_is_8bit;
    logic [31:0] eip, dec_eip, dec_imm;
    logic [2:0]  dec_reg;
    rep_t        dec_rep;
    seg_t        dec_seg;
    dec_cmd_t    dec_cmd;

    logic [7:0]  stream[$];                       // all rows back to back
    logic        c_d32[$], c_is8[$], c_op32[$];
    logic [2:0]  c_cmd[$], c_reg[$], c_seg[$];
    logic [1:0]  c_rep[$];
    logic [31:0] c_imm[$];
    logic [3:0]  c_used[$];

    decode dut0 (.*);

    // bytes written first leftmost come back head lowest
    function automatic logic [63:0] pack_bytes(input int n, input logic [63:0] v);
        logic [63:0] r;
        r = 64'd0;
        for (int i = 0; i < n; i++) r[i*8 +: 8] = v[(n-1-i)*8 +: 8];
        return r;
    endfunction

    task automatic add_case(input int n, input logic [63:0] v, input int d32,
        input logic [2:0] cmd, input int rg, input int is8, input logic [31:0] imm,
        input logic [1:0] rep, input logic [2:0] seg, input int op32, input int used);
        logic [63:0] b;
        b = pack_bytes(n, v);
        for (int i = 0; i < n; i++) stream.push_back(b[i*8 +: 8]);
        c_d32.push_back(1'(d32));
        c_cmd.push_back(cmd);
        c_reg.push_back(3'(rg));
        c_is8.push_back(1'(is8));
        c_imm.push_back(imm);
        c_rep.push_back(rep);
        c_seg.push_back(seg);
        c_op32.push_back(1'(op32));
        c_used.push_back(4'(used));
    endtask

    `include "decode_tb_cases.svh"

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic report_failure(input string what);
        $display("%s at %0t", what, $time);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            report_failure("value check failed");
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                     // 8 ns period
    end

    // watchdog allows 40 cycles per row plus the fault phases
    initial begin
        #1;
        #(longint'(c_cmd.size() * 40 + 400) * 8);
        report_failure("watchdog timeout, run did not finish");
    end

    //--------------------------------------
    task automatic clear_faults();
        @(negedge clk) dec_reset = 1'b1;
        @(negedge clk) dec_reset = 1'b0;
        #1;
        check_val("dec_ud_fault", 32'(dec_ud_fault), 32'd0);
        check_val("dec_gp_fault", 32'(dec_gp_fault), 32'd0);
        check_val("dec_pf_fault", 32'(dec_pf_fault), 32'd0);
    endtask

    task automatic feed(input int n, input logic [63:0] v);
        @(negedge clk);
        fetch_valid = 4'(n);
        fetch       = pack_bytes(n, v);
        @(negedge clk);
        fetch_valid = 4'd0;
        fetch       = 64'd0;
    endtask

    task automatic expect_nop();
        int i;
        feed(1, 64'h90);
        for (i = 0; i < 10; i++) begin
            #1;
            if (dec_ready) break;
            @(negedge clk);
        end
        assert (i < 10) else report_failure("no dec_ready after fault cleared");
        check_val("dec_cmd", 32'(dec_cmd), 32'(cmd_nop));
        check_val("dec_consumed", 32'(dec_consumed), 32'd1);
    endtask

    task automatic run_ud_case(input int n, input logic [63:0] v, input logic exp_lock);
        int i;
        feed(n, v);
        for (i = 0; i < 10; i++) begin
            #1;
            check_val("dec_ready", 32'(dec_ready), 32'd0);
            if (dec_ud_fault) break;
            @(negedge clk);
        end
        assert (i < 10) else report_failure("dec_ud_fault did not rise");
        check_val("dec_lock", 32'(dec_lock), 32'(exp_lock));
        repeat (4) begin                            // sticky with no issue
            @(negedge clk);
            #1;
            check_val("dec_ud_fault", 32'(dec_ud_fault), 32'd1);
            check_val("dec_ready", 32'(dec_ready), 32'd0);
        end
        clear_faults();
        expect_nop();
    endtask

    task automatic run_limit_case(input logic use_pf);
        int i;
        feed(1, 64'hb8);                            // needs 5 bytes at 32 bit
        fetch_limit      = !use_pf;                 // one cycle only
        fetch_page_fault = use_pf;
        @(negedge clk);
        fetch_limit      = 1'b0;
        fetch_page_fault = 1'b0;
        repeat (3) begin
            @(negedge clk);
            #1;
            check_val("dec_gp_fault", 32'(dec_gp_fault), 32'd0);
            check_val("dec_pf_fault", 32'(dec_pf_fault), 32'd0);
        end
        @(negedge clk);
        fetch_limit      = !use_pf;
        fetch_page_fault = use_pf;
        for (i = 0; i < 10; i++) begin
            @(negedge clk);
            #1;
            if (dec_gp_fault || dec_pf_fault) break;
        end
        assert (i < 10) else report_failure("fetch fault did not rise");
        check_val("dec_gp_fault", 32'(dec_gp_fault), 32'(!use_pf));
        check_val("dec_pf_fault", 32'(dec_pf_fault), 32'(use_pf));
        fetch_limit      = 1'b0;
        fetch_page_fault = 1'b0;
        clear_faults();
    endtask

    //--------------------------------------
    initial begin
        logic [31:0] rnd, exp_eip;
        int ptr, row, cyc, fvi, take, busy_left, busy_run;
        rst_n            = 1'b0;
        dec_reset        = 1'b0;
        default_32bit    = 1'b1;
        pr_reset         = 1'b0;
        micro_busy       = 1'b0;
        fetch_limit      = 1'b0;
        fetch_page_fault = 1'b0;
        prefetch_eip     = 32'd0;
        fetch_valid      = 4'd0;
        fetch            = 64'd0;
        load_cases();
        rnd       = 32'h1e9578c0;
        ptr       = 0;
        row       = 0;
        cyc       = 0;
        busy_left = 0;
        busy_run  = 0;
        exp_eip   = startup_eip;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        #1;
        check_val("dec_ready", 32'(dec_ready), 32'd0);
        check_val("dec_consumed", 32'(dec_consumed), 32'd0);
        check_val("dec_gp_fault", 32'(dec_gp_fault), 32'd0);
        check_val("dec_ud_fault", 32'(dec_ud_fault), 32'd0);
        check_val("dec_pf_fault", 32'(dec_pf_fault), 32'd0);
        check_val("eip", eip, startup_eip);

        while (row < c_cmd.size()) begin
            @(negedge clk);
            rnd = xorshift(rnd);
            fvi = int'(rnd % 32'd9);
            if (fvi > stream.size() - ptr) fvi = stream.size() - ptr;
            if (cyc == 12) busy_left = 24;          // long stall so the window fills
            else if (busy_left == 0 && rnd[15:12] == 4'd0) busy_left = 1 + int'(rnd[19:16]);
            micro_busy = (busy_left > 0);
            if (busy_left > 0) busy_left--;
            busy_run = micro_busy ? busy_run + 1 : 0;
            default_32bit = c_d32[row];
            pr_reset      = (cyc == 40);
            prefetch_eip  = 32'h0002_4000;
            fetch = 64'd0;
            for (int i = 0; i < fvi; i++) fetch[i*8 +: 8] = stream[ptr + i];
            fetch_valid = 4'(fvi);
            #1;
            take = (fvi < int'(dec_acceptable)) ? fvi : int'(dec_acceptable);
            check_val("eip", eip, exp_eip);
            if (micro_busy) check_val("dec_ready", 32'(dec_ready), 32'd0);
            if (busy_run == 20 && ptr < stream.size())
                check_val("dec_acceptable", 32'(dec_acceptable), 32'd0);
            if (dec_ready) begin
                check_val("dec_cmd", 32'(dec_cmd), 32'(c_cmd[row]));
                check_val("dec_reg", 32'(dec_reg), 32'(c_reg[row]));
                check_val("dec_is_8bit", 32'(dec_is_8bit), 32'(c_is8[row]));
                check_val("dec_imm", dec_imm, c_imm[row]);
                check_val("dec_rep", 32'(dec_rep), 32'(c_rep[row]));
                check_val("dec_seg", 32'(dec_seg), 32'(c_seg[row]));
                check_val("dec_lock", 32'(dec_lock), 32'd0);   // locked instr never issues
                check_val("dec_operand_32bit", 32'(dec_operand_32bit), 32'(c_op32[row]));
                check_val("dec_consumed", 32'(dec_consumed), 32'(c_used[row]));
                check_val("dec_eip", dec_eip, exp_eip + 32'(c_used[row]));
                exp_eip = exp_eip + 32'(c_used[row]);
                row++;
            end
            if (pr_reset) exp_eip = prefetch_eip;   // redirect wins over ready
            ptr += take;
            cyc++;
        end
        @(negedge clk);
        fetch_valid   = 4'd0;
        micro_busy    = 1'b0;
        pr_reset      = 1'b0;
        default_32bit = 1'b1;

        // fault phases
        run_ud_case(1, 64'hd6, 1'b0);               // unsupported opcode
        run_ud_case(2, 64'h0f0b, 1'b0);             // unsupported 0f second byte
        run_ud_case(2, 64'hf090, 1'b1);             // lock on nop
        run_limit_case(1'b0);
        run_limit_case(1'b1);
        expect_nop();
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+test
rtl/decode_pkg.sv
rtl/decode_regs.sv
rtl/decode_prefix.sv
rtl/decode_length.sv
rtl/decode_ctrl.sv
rtl/decode.sv
test/decode_tb.sv

//--- Makefile
# Verilator build and run for the decode stage

VERILATOR ?= verilator
TOP       ?= decode_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
